//--- source/yuv_rgb_pkg.sv
package yuv_rgb_pkg;

	// line and lane geometry
	localparam int LINE_PAIRS      = 160;
	localparam int NUM_LANES       = 3;
	localparam int LANE_FIFO_DEPTH = 4;
	localparam int IN_FIFO_DEPTH   = 4;

	// six-tap odd chroma filter, middle tap is subtracted
	localparam int FIR_TAP_OUTER  = 21;
	localparam int FIR_TAP_MIDDLE = 52;
	localparam int FIR_TAP_INNER  = 159;
	localparam int FIR_ROUND      = 128;
	localparam int FIR_SHIFT      = 8;

	// colour conversion in 16-bit fixed point
	localparam int Y_OFFSET  = 16;
	localparam int C_OFFSET  = 128;
	localparam int K_Y       = 76284;
	localparam int K_RV      = 104595;
	localparam int K_GU      = 25624;
	localparam int K_GV      = 53281;
	localparam int K_BU      = 132251;
	localparam int CSC_SHIFT = 16;

	typedef logic [7:0] pixel_t;

	typedef struct packed {
		pixel_t y_even;
		pixel_t y_odd;
		pixel_t u;
		pixel_t v;
	} yuv422_pair_t;

	typedef struct packed {
		pixel_t y_even;
		pixel_t y_odd;
		pixel_t u_even;
		pixel_t v_even;
		pixel_t u_odd;
		pixel_t v_odd;
	} yuv444_pair_t;

	typedef struct packed {
		pixel_t r;
		pixel_t g;
		pixel_t b;
	} rgb_t;

	typedef struct packed {
		rgb_t pix_even;
		rgb_t pix_odd;
	} rgb_pair_t;

	typedef logic [1:0] lane_idx_t;

	// saturate a signed result to the 8-bit sample range
	function automatic pixel_t clip_pixel(input int value);
		if (value < 0) begin
			return 8'd0;
		end
		if (value > 255) begin
			return 8'd255;
		end
		return pixel_t'(value);
	endfunction

endpackage

//--- source/stream_fifo.sv
`timescale 1ns/10ps

module stream_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic CLOCK_50_I,
	input logic Resetn,
	input payload_t wr_data,
	input logic wr_valid,
	output logic wr_ready,
	output payload_t rd_data,
	output logic rd_valid,
	input logic rd_ready,
	output logic [$clog2(DEPTH + 1)-1:0] count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count_next;
	logic push, pop;

	assign push = wr_valid && wr_ready;
	assign pop = rd_valid && rd_ready;
	assign rd_valid = (count != '0);
	assign rd_data = mem[rd_ptr];

	always_comb begin
		count_next = count;
		if (push && !pop) begin
			count_next = count + 1'b1;
		end else if (pop && !push) begin
			count_next = count - 1'b1;
		end
	end

	// ready is registered so it stays low through reset
	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			wr_ready <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count_next;
			wr_ready <= (count_next != CNT_W'(DEPTH));
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (push) begin
			mem[wr_ptr] <= wr_data;
		end
	end

endmodule

//--- source/chroma_upsampler.sv
`timescale 1ns/10ps

module chroma_upsampler (
	input logic CLOCK_50_I,
	input logic Resetn,
	input yuv_rgb_pkg::yuv422_pair_t in_pair,
	input logic in_valid,
	output logic in_ready,
	output yuv_rgb_pkg::yuv444_pair_t lane_pair,
	output logic [yuv_rgb_pkg::NUM_LANES-1:0] lane_valid,
	input logic [yuv_rgb_pkg::NUM_LANES-1:0] lane_ready
);

	import yuv_rgb_pkg::*;

	localparam int CNT_W = $clog2(LINE_PAIRS);

	typedef struct packed {
		pixel_t y_even;
		pixel_t y_odd;
	} luma_pair_t;

	// window holds chroma of pairs k-2 .. k+3 once pair k+3 is in
	pixel_t u_win [6];
	pixel_t v_win [6];
	pixel_t u_next [6];
	pixel_t v_next [6];
	luma_pair_t y_q [3];

	logic [CNT_W-1:0] pair_cnt;
	logic [1:0] flush_left;
	lane_idx_t disp_ptr;
	logic out_vld;
	logic flushing, preload;
	logic out_free, dispatched;
	logic accept, flush_step, emit;

	function automatic pixel_t fir6(input pixel_t w [6]);
		int acc;
		acc = FIR_TAP_OUTER * (int'(w[0]) + int'(w[5]))
			- FIR_TAP_MIDDLE * (int'(w[1]) + int'(w[4]))
			+ FIR_TAP_INNER * (int'(w[2]) + int'(w[3]))
			+ FIR_ROUND;
		return clip_pixel(acc >>> FIR_SHIFT);
	endfunction

	assign flushing = (flush_left != 2'd0);
	assign preload = !flushing && (pair_cnt == '0);

	// output register is free when empty or being taken this cycle
	assign dispatched = out_vld && lane_ready[disp_ptr];
	assign out_free = !out_vld || lane_ready[disp_ptr];

	assign in_ready = out_free && !flushing;
	assign accept = in_valid && in_ready;
	assign flush_step = flushing && out_free;
	assign emit = (accept && (pair_cnt >= CNT_W'(3))) || flush_step;

	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			lane_valid[i] = out_vld && (disp_ptr == lane_idx_t'(i));
		end
	end

	// next window: preload at line start, repeat the last sample in the flush
	always_comb begin
		for (int i = 0; i < 5; i++) begin
			u_next[i] = preload ? in_pair.u : u_win[i+1];
			v_next[i] = preload ? in_pair.v : v_win[i+1];
		end
		u_next[5] = flushing ? u_win[5] : in_pair.u;
		v_next[5] = flushing ? v_win[5] : in_pair.v;
	end

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			pair_cnt <= '0;
			flush_left <= 2'd0;
			disp_ptr <= '0;
			out_vld <= 1'b0;
		end else begin
			if (dispatched) begin
				disp_ptr <= (disp_ptr == lane_idx_t'(NUM_LANES - 1)) ? '0 : disp_ptr + 2'd1;
			end
			if (emit) begin
				out_vld <= 1'b1;
			end else if (dispatched) begin
				out_vld <= 1'b0;
			end
			if (accept) begin
				if (pair_cnt == CNT_W'(LINE_PAIRS - 1)) begin
					pair_cnt <= '0;
					flush_left <= 2'd3;
				end else begin
					pair_cnt <= pair_cnt + 1'b1;
				end
			end
			if (flush_step) begin
				flush_left <= flush_left - 2'd1;
			end
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (accept || flush_step) begin
			u_win <= u_next;
			v_win <= v_next;
			y_q[0] <= y_q[1];
			y_q[1] <= y_q[2];
			if (accept) begin
				y_q[2] <= '{y_even: in_pair.y_even, y_odd: in_pair.y_odd};
			end
		end
		// oldest queued luma goes out with the centred chroma
		if (emit) begin
			lane_pair.y_even <= y_q[0].y_even;
			lane_pair.y_odd <= y_q[0].y_odd;
			lane_pair.u_even <= u_next[2];
			lane_pair.v_even <= v_next[2];
			lane_pair.u_odd <= fir6(u_next);
			lane_pair.v_odd <= fir6(v_next);
		end
	end

endmodule

//--- source/csc_lane.sv
`timescale 1ns/10ps

module csc_lane (
	input logic CLOCK_50_I,
	input logic Resetn,
	input yuv_rgb_pkg::yuv444_pair_t pair_in,
	input logic pair_valid,
	output logic pair_ready,
	output yuv_rgb_pkg::rgb_pair_t res_pair,
	output logic res_valid,
	input logic res_ready
);

	import yuv_rgb_pkg::*;

	localparam int CNT_W = $clog2(LANE_FIFO_DEPTH + 1);

	typedef struct packed {
		logic signed [8:0] y;
		logic signed [8:0] u;
		logic signed [8:0] v;
	} yuv_s_t;

	typedef struct packed {
		logic signed [31:0] y;
		logic signed [31:0] rv;
		logic signed [31:0] gu;
		logic signed [31:0] gv;
		logic signed [31:0] bu;
	} prod_t;

	// index 0 is the even pixel, 1 the odd
	yuv_s_t [1:0] s1_q;
	prod_t [1:0] s2_q;
	rgb_pair_t s3_q;
	logic s1_v, s2_v, s3_v;
	logic [1:0] in_flight;
	logic [CNT_W-1:0] fifo_count;
	logic fifo_wr_ready;
	logic accept;

	function automatic yuv_s_t remove_offsets(input pixel_t y, input pixel_t u, input pixel_t v);
		yuv_s_t s;
		s.y = 9'($signed({1'b0, y}) - Y_OFFSET);
		s.u = 9'($signed({1'b0, u}) - C_OFFSET);
		s.v = 9'($signed({1'b0, v}) - C_OFFSET);
		return s;
	endfunction

	function automatic prod_t products(input yuv_s_t s);
		prod_t p;
		p.y = s.y * K_Y;
		p.rv = s.v * K_RV;
		p.gu = s.u * K_GU;
		p.gv = s.v * K_GV;
		p.bu = s.u * K_BU;
		return p;
	endfunction

	function automatic rgb_t combine(input prod_t p);
		rgb_t c;
		c.r = clip_pixel((p.y + p.rv) >>> CSC_SHIFT);
		c.g = clip_pixel((p.y - p.gu - p.gv) >>> CSC_SHIFT);
		c.b = clip_pixel((p.y + p.bu) >>> CSC_SHIFT);
		return c;
	endfunction

	// credits cover the three stages so the FIFO never overflows
	assign in_flight = {1'b0, s1_v} + {1'b0, s2_v} + {1'b0, s3_v};
	assign pair_ready = fifo_wr_ready
		&& (int'(fifo_count) + int'(in_flight) < LANE_FIFO_DEPTH);
	assign accept = pair_valid && pair_ready;

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			s1_v <= 1'b0;
			s2_v <= 1'b0;
			s3_v <= 1'b0;
		end else begin
			s1_v <= accept;
			s2_v <= s1_v;
			s3_v <= s2_v;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (accept) begin
			s1_q[0] <= remove_offsets(pair_in.y_even, pair_in.u_even, pair_in.v_even);
			s1_q[1] <= remove_offsets(pair_in.y_odd, pair_in.u_odd, pair_in.v_odd);
		end
		if (s1_v) begin
			s2_q[0] <= products(s1_q[0]);
			s2_q[1] <= products(s1_q[1]);
		end
		if (s2_v) begin
			s3_q.pix_even <= combine(s2_q[0]);
			s3_q.pix_odd <= combine(s2_q[1]);
		end
	end

	stream_fifo #(
		.payload_t(rgb_pair_t),
		.DEPTH(LANE_FIFO_DEPTH)
	) u_res_fifo (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.wr_data(s3_q),
		.wr_valid(s3_v),
		.wr_ready(fifo_wr_ready),
		.rd_data(res_pair),
		.rd_valid(res_valid),
		.rd_ready(res_ready),
		.count(fifo_count)
	);

endmodule

//--- source/rgb_word_packer.sv
`timescale 1ns/10ps

module rgb_word_packer (
	input logic CLOCK_50_I,
	input logic Resetn,
	input yuv_rgb_pkg::rgb_pair_t [yuv_rgb_pkg::NUM_LANES-1:0] res_pair,
	input logic [yuv_rgb_pkg::NUM_LANES-1:0] res_valid,
	output logic [yuv_rgb_pkg::NUM_LANES-1:0] res_ready,
	output logic [15:0] out_word,
	output logic out_valid,
	input logic out_ready
);

	import yuv_rgb_pkg::*;

	lane_idx_t rd_ptr, nxt_ptr;
	rgb_pair_t held_pair;
	logic held;
	logic [1:0] phase;
	logic last_word;

	assign nxt_ptr = (rd_ptr == lane_idx_t'(NUM_LANES - 1)) ? '0 : rd_ptr + 2'd1;
	assign last_word = held && out_ready && (phase == 2'd2);
	assign out_valid = held;

	// the lane is popped only once its third word has gone
	always_comb begin
		res_ready = '0;
		res_ready[rd_ptr] = last_word;
	end

	always_comb begin
		case (phase)
			2'd0: out_word = {held_pair.pix_even.r, held_pair.pix_even.g};
			2'd1: out_word = {held_pair.pix_even.b, held_pair.pix_odd.r};
			default: out_word = {held_pair.pix_odd.g, held_pair.pix_odd.b};
		endcase
	end

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			rd_ptr <= '0;
			phase <= 2'd0;
			held <= 1'b0;
		end else begin
			if (last_word) begin
				rd_ptr <= nxt_ptr;
				phase <= 2'd0;
				// next lane loads straight away so words stay back to back
				held <= res_valid[nxt_ptr];
			end else if (held && out_ready) begin
				phase <= phase + 2'd1;
			end else if (!held && res_valid[rd_ptr]) begin
				held <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (last_word) begin
			held_pair <= res_pair[nxt_ptr];
		end else if (!held) begin
			held_pair <= res_pair[rd_ptr];
		end
	end

endmodule

//--- source/yuv_to_rgb_top.sv
`timescale 1ns/10ps

module yuv_to_rgb_top (
	input logic CLOCK_50_I,
	input logic Resetn,
	input yuv_rgb_pkg::yuv422_pair_t in_pair,
	input logic in_valid,
	output logic in_ready,
	output logic [15:0] out_word,
	output logic out_valid,
	input logic out_ready
);

	import yuv_rgb_pkg::*;

	yuv422_pair_t fifo_pair;
	logic fifo_valid, fifo_ready;
	yuv444_pair_t lane_pair;
	logic [NUM_LANES-1:0] lane_valid, lane_ready;
	rgb_pair_t [NUM_LANES-1:0] res_pair;
	logic [NUM_LANES-1:0] res_valid, res_ready;

	stream_fifo #(
		.payload_t(yuv422_pair_t),
		.DEPTH(IN_FIFO_DEPTH)
	) u_in_fifo (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.wr_data(in_pair),
		.wr_valid(in_valid),
		.wr_ready(in_ready),
		.rd_data(fifo_pair),
		.rd_valid(fifo_valid),
		.rd_ready(fifo_ready),
		.count()
	);

	chroma_upsampler u_upsampler (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.in_pair(fifo_pair),
		.in_valid(fifo_valid),
		.in_ready(fifo_ready),
		.lane_pair(lane_pair),
		.lane_valid(lane_valid),
		.lane_ready(lane_ready)
	);

	// all lanes see the same pair, only the addressed one sees valid
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		csc_lane u_lane (
			.CLOCK_50_I(CLOCK_50_I),
			.Resetn(Resetn),
			.pair_in(lane_pair),
			.pair_valid(lane_valid[i]),
			.pair_ready(lane_ready[i]),
			.res_pair(res_pair[i]),
			.res_valid(res_valid[i]),
			.res_ready(res_ready[i])
		);
	end

	rgb_word_packer u_packer (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.res_pair(res_pair),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.out_word(out_word),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

//--- verif/yuv_to_rgb_checker.sv
`timescale 1ns/10ps

module yuv_to_rgb_checker (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic [15:0] out_word,
	input logic out_valid,
	input logic out_ready
);

	// a stalled word stays on the bus unchanged until taken
	property word_held_while_stalled;
		@(posedge CLOCK_50_I) disable iff (!Resetn)
			(out_valid && !out_ready) |=> (out_valid && $stable(out_word));
	endproperty

	property valid_known;
		@(posedge CLOCK_50_I) disable iff (!Resetn)
			!$isunknown(out_valid);
	endproperty

	property word_known_when_valid;
		@(posedge CLOCK_50_I) disable iff (!Resetn)
			out_valid |-> !$isunknown(out_word);
	endproperty

	a_word_held: assert property (word_held_while_stalled)
		else $error("out_word changed or was withdrawn while out_ready was low");

	a_valid_known: assert property (valid_known)
		else $error("out_valid is unknown after reset");

	a_word_known: assert property (word_known_when_valid)
		else $error("out_word is unknown while out_valid is high");

endmodule

bind rgb_word_packer yuv_to_rgb_checker u_checker (
	.CLOCK_50_I(CLOCK_50_I),
	.Resetn(Resetn),
	.out_word(out_word),
	.out_valid(out_valid),
	.out_ready(out_ready)
);

//--- verif/yuv_rgb_model.svh
`ifndef YUV_RGB_MODEL_SVH
`define YUV_RGB_MODEL_SVH

// reference arithmetic for the converter, included into the testbench module

function automatic logic [7:0] saturate(input int value);
	if (value < 0) begin
		return 8'h00;
	end else if (value > 255) begin
		return 8'hff;
	end
	return 8'(value);
endfunction

// positions past either end of the line reuse the edge sample
function automatic int edge_index(input int k);
	if (k < 0) begin
		return 0;
	end else if (k > LINE_PAIRS - 1) begin
		return LINE_PAIRS - 1;
	end
	return k;
endfunction

// chroma halfway between pair k and pair k+1
function automatic logic [7:0] odd_chroma(input logic [7:0] c [LINE_PAIRS], input int k);
	int acc;
	acc = FIR_TAP_OUTER * (int'(c[edge_index(k - 2)]) + int'(c[edge_index(k + 3)]));
	acc = acc - FIR_TAP_MIDDLE * (int'(c[edge_index(k - 1)]) + int'(c[edge_index(k + 2)]));
	acc = acc + FIR_TAP_INNER * (int'(c[edge_index(k)]) + int'(c[edge_index(k + 1)]));
	return saturate((acc + FIR_ROUND) >>> FIR_SHIFT);
endfunction

function automatic logic [23:0] to_rgb(input logic [7:0] y, input logic [7:0] u,
		input logic [7:0] v);
	int ys;
	int us;
	int vs;
	logic [7:0] r;
	logic [7:0] g;
	logic [7:0] b;
	ys = int'(y) - Y_OFFSET;
	us = int'(u) - C_OFFSET;
	vs = int'(v) - C_OFFSET;
	r = saturate((K_Y * ys + K_RV * vs) >>> CSC_SHIFT);
	g = saturate((K_Y * ys - K_GU * us - K_GV * vs) >>> CSC_SHIFT);
	b = saturate((K_Y * ys + K_BU * us) >>> CSC_SHIFT);
	return {r, g, b};
endfunction

// three output words of pair k, first word in the top bits
function automatic logic [47:0] pair_words(input logic [7:0] u_line [LINE_PAIRS],
		input logic [7:0] v_line [LINE_PAIRS], input yuv422_pair_t p, input int k);
	logic [23:0] pix_e;
	logic [23:0] pix_o;
	logic [15:0] w0;
	logic [15:0] w1;
	logic [15:0] w2;
	pix_e = to_rgb(p.y_even, u_line[k], v_line[k]);
	pix_o = to_rgb(p.y_odd, odd_chroma(u_line, k), odd_chroma(v_line, k));
	w0 = {pix_e[23:16], pix_e[15:8]};
	w1 = {pix_e[7:0], pix_o[23:16]};
	w2 = {pix_o[15:8], pix_o[7:0]};
	return {w0, w1, w2};
endfunction

`endif

//--- verif/tb_yuv_to_rgb.sv
`timescale 1ns/10ps

module tb_yuv_to_rgb;

	import yuv_rgb_pkg::*;

	localparam int NUM_LINES = 3;
	localparam int NUM_PAIRS = NUM_LINES * LINE_PAIRS;
	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int STALL_MARGIN = 8;
	localparam int TIMEOUT_NS = (RESET_CYCLES + NUM_PAIRS * 3 * STALL_MARGIN) * CLK_PERIOD;

	logic CLOCK_50_I;
	logic Resetn;
	yuv422_pair_t in_pair;
	logic in_valid;
	logic in_ready;
	logic [15:0] out_word;
	logic out_valid;
	logic out_ready;

	integer seed;
	yuv422_pair_t stim [NUM_PAIRS];
	logic [15:0] expected_words [$];
	int words_seen;

	`include "yuv_rgb_model.svh"

	yuv_to_rgb_top dut_i (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.in_pair(in_pair),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_word(out_word),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	initial CLOCK_50_I = 1'b0;
	always #(CLK_PERIOD / 2) CLOCK_50_I = ~CLOCK_50_I;

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error: %s is 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	// mostly random samples, with both extremes mixed in
	function automatic logic [7:0] random_sample();
		int pick;
		pick = $unsigned($random(seed)) % 16;
		if (pick == 0) begin
			return 8'h00;
		end else if (pick == 1) begin
			return 8'hff;
		end
		return 8'($random(seed));
	endfunction

	task automatic make_stimulus();
		for (int i = 0; i < NUM_PAIRS; i++) begin
			stim[i].y_even = random_sample();
			stim[i].y_odd = random_sample();
			stim[i].u = random_sample();
			stim[i].v = random_sample();
			if (i % 37 == 5) begin
				stim[i] = '1;
			end else if (i % 37 == 20) begin
				stim[i] = '0;
			end
		end
	endtask

	task automatic build_expected();
		logic [7:0] u_line [LINE_PAIRS];
		logic [7:0] v_line [LINE_PAIRS];
		logic [47:0] words;
		for (int line = 0; line < NUM_LINES; line++) begin
			for (int k = 0; k < LINE_PAIRS; k++) begin
				u_line[k] = stim[line * LINE_PAIRS + k].u;
				v_line[k] = stim[line * LINE_PAIRS + k].v;
			end
			for (int k = 0; k < LINE_PAIRS; k++) begin
				words = pair_words(u_line, v_line, stim[line * LINE_PAIRS + k], k);
				expected_words.push_back(words[47:32]);
				expected_words.push_back(words[31:16]);
				expected_words.push_back(words[15:0]);
			end
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge CLOCK_50_I);
			#1;
		end
	endtask

	// in_ready is registered, so its value here decides the next edge
	task automatic send_pair(input yuv422_pair_t p);
		logic taken;
		in_pair = p;
		in_valid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			taken = in_ready;
			idle_cycles(1);
		end
		in_valid = 1'b0;
	endtask

	task automatic drive_stimulus();
		for (int i = 0; i < NUM_PAIRS; i++) begin
			if (($random(seed) & 7) == 0) begin
				idle_cycles(1 + $unsigned($random(seed)) % 4);
			end
			send_pair(stim[i]);
		end
	endtask

	task automatic drain_words();
		logic [15:0] expected;
		while (words_seen < NUM_PAIRS * 3) begin
			@(posedge CLOCK_50_I);
			#1;
			out_ready = (($random(seed) & 3) != 0);
			#1;
			if (out_valid && out_ready) begin
				expected = expected_words.pop_front();
				check_value("out_word", out_word, expected);
				words_seen++;
			end
		end
	endtask

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("timeout: the DUT did not deliver all output words in time");
		$display("Test failures found");
		$fatal(1);
	end

	initial begin : main_sequence
		seed = 32'he122;
		Resetn = 1'b0;
		in_pair = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		words_seen = 0;
		make_stimulus();
		build_expected();
		repeat (RESET_CYCLES) begin
			idle_cycles(1);
			check_value("out_valid", out_valid, 1'b0);
			check_value("in_ready", in_ready, 1'b0);
		end
		Resetn = 1'b1;
		out_ready = 1'b1;
		idle_cycles(1);
		check_value("in_ready", in_ready, 1'b1);
		// nothing may come out before the first pair goes in
		repeat (8) begin
			idle_cycles(1);
			check_value("out_valid", out_valid, 1'b0);
		end
		fork
			drive_stimulus();
			drain_words();
		join
		// any word beyond three per pair shows up here
		out_ready = 1'b1;
		repeat (20) begin
			@(posedge CLOCK_50_I);
			#2;
			check_value("out_valid", out_valid, 1'b0);
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

//--- sources.f
+incdir+verif
source/yuv_rgb_pkg.sv
source/stream_fifo.sv
source/chroma_upsampler.sv
source/csc_lane.sv
source/rgb_word_packer.sv
source/yuv_to_rgb_top.sv
verif/yuv_to_rgb_checker.sv
verif/tb_yuv_to_rgb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the YUV to RGB testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_yuv_to_rgb -f sources.f -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "All tests passed!" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
